/* Makefile */
# Verilator build and run of the heap testbench
TOP = heapTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* arrayBank.sv */
//----------------------------------------------------------
// One array of the heap. Trusts the decoder for legality;
// results come from contents before the edge. Elements at
// or above the size hold stale data.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

module arrayBank (
  input  logic              clock,
  input  logic              resetN,
  input  logic              select,
  input  logic              clear,
  input  heapPkg::actionT   action,
  input  heapPkg::indexT    index,
  input  heapPkg::elementT  dataIn,
  output heapPkg::sizeT     size,
  output heapPkg::elementT  result
);
  import heapPkg::*;

  elementT storage [`HEAP_LENGTH];                // Element storage
  elementT current;                               // Element at index
  elementT newValue;                              // Arithmetic outcome
  elementT topValue;                              // Element a pop removes
  indexT   topIndex;
  sizeT    matchPos;                              // Last match plus one
  sizeT    lessCount;
  sizeT    greaterCount;

  assign current  = storage[index];
  assign topIndex = indexT'(size - 1'b1);
  assign topValue = storage[topIndex];

  // ---------------------------------------------------------
  // Datapath
  // ---------------------------------------------------------
  always_comb begin
    case (action)
      actAdd, actAddAfter:      newValue = current + dataIn;
      actSubtract, actSubAfter: newValue = current - dataIn;
      actOr:                    newValue = current | dataIn;
      actXor:                   newValue = current ^ dataIn;
      default:                  newValue = current & dataIn;
    endcase
  end

  // Searches over live elements only
  always_comb begin
    matchPos     = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      if (sizeT'(i) < size) begin
        if (storage[i] == dataIn)
          matchPos = sizeT'(i + 1);               // Later matches win
        if (storage[i] < dataIn)
          lessCount = lessCount + 1'b1;
        if (storage[i] > dataIn)
          greaterCount = greaterCount + 1'b1;
      end
    end
  end

  always_comb begin
    case (action)
      actRead, actAddAfter, actSubAfter:
        result = current;                         // Old value
      actAdd, actSubtract, actOr, actXor, actAnd:
        result = newValue;
      actPop:     result = topValue;
      actSize:    result = elementT'(size);
      actIndex:   result = elementT'(matchPos);
      actLess:    result = elementT'(lessCount);
      actGreater: result = elementT'(greaterCount);
      default:    result = '0;
    endcase
  end

  // ---------------------------------------------------------
  // State
  // ---------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      size <= '0;
    else if (clear)
      size <= '0;                                 // Alloc or heap clear
    else if (select) begin
      case (action)
        actWrite:
          if ({1'b0, index} >= size)
            size <= {1'b0, index} + 1'b1;         // Grow to cover index
        actPush: size <= size + 1'b1;
        actPop:  size <= size - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (select) begin
      case (action)
        actWrite: storage[index] <= dataIn;
        actPush:  storage[size[`HEAP_INDEX_BITS-1:0]] <= dataIn;
        actAdd, actAddAfter, actSubtract, actSubAfter, actOr, actXor, actAnd:
          storage[index] <= newValue;             // Read-modify-write
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* commandDecoder.sv */
//----------------------------------------------------------
// Legality checks and allocation state for the heap.
// Outputs are combinational from the current inputs; the
// free stack is LIFO and cannot overflow since double
// frees are rejected.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

module commandDecoder (
  input  logic               clock,
  input  logic               resetN,
  input  heapPkg::actionT    action,
  input  heapPkg::arrayNumT  array,
  input  heapPkg::indexT     index,
  input  heapPkg::sizeT      bankSizes [`HEAP_ARRAYS],
  output logic [`HEAP_ARRAYS-1:0] bankSelect,
  output logic [`HEAP_ARRAYS-1:0] bankClear,
  output heapPkg::actionT    bankAction,
  output heapPkg::arrayNumT  allocResult,
  output heapPkg::errorT     cmdError
);
  import heapPkg::*;

  logic [`HEAP_ARRAYS-1:0]    allocated;          // Live arrays
  logic [`HEAP_ADDRESS_BITS:0] highWater;         // Arrays ever handed out
  logic [`HEAP_ADDRESS_BITS:0] freeTop;           // Entries on free stack
  arrayNumT                   freeStack [`HEAP_ARRAYS];
  arrayNumT                   topSlot;            // Slot of newest freed array
  sizeT                       selSize;            // Size of addressed array
  logic                       reuse;              // Free stack not empty
  logic                       needAlloc;          // Action targets one array
  logic                       needIndex;          // Index must be below size

  assign bankAction = action;
  assign selSize    = bankSizes[array];
  assign reuse      = (freeTop != '0);
  assign topSlot    = freeTop[`HEAP_ADDRESS_BITS-1:0] - 1'b1;
  assign allocResult = reuse ? freeStack[topSlot] : highWater[`HEAP_ADDRESS_BITS-1:0];

  // ---------------------------------------------------------
  // Legality
  // ---------------------------------------------------------
  always_comb begin
    needAlloc = 1'b0;
    needIndex = 1'b0;
    case (action)
      actWrite, actSize, actFree, actIndex, actLess, actGreater, actPush, actPop:
        needAlloc = 1'b1;
      actRead, actAdd, actAddAfter, actSubtract, actSubAfter, actOr, actXor, actAnd: begin
        needAlloc = 1'b1;
        needIndex = 1'b1;
      end
      default: ;
    endcase

    cmdError = errNone;
    if (action == actAlloc && !reuse && highWater[`HEAP_ADDRESS_BITS])
      cmdError = errOutOfMemory;                  // Every array in use
    else if (needAlloc) begin
      if ({1'b0, array} >= highWater)
        cmdError = errNotAllocated;               // Never handed out
      else if (!allocated[array])
        cmdError = errFreed;
      else if (needIndex && {1'b0, index} >= selSize)
        cmdError = errOutOfBounds;
      else if (action == actPush && selSize[`HEAP_INDEX_BITS])
        cmdError = errFull;                       // Size at full length
      else if (action == actPop && selSize == '0)
        cmdError = errEmpty;
    end
  end

  // One bank acted on, or cleared, per legal action
  always_comb begin
    bankSelect = '0;
    bankClear  = '0;
    if (cmdError == errNone) begin
      if (action == actClearHeap)
        bankClear = '1;                           // Empty all arrays
      else if (action == actAlloc)
        bankClear[allocResult] = 1'b1;            // Fresh array starts empty
      else if (needAlloc)
        bankSelect[array] = 1'b1;
    end
  end

  // ---------------------------------------------------------
  // Allocation state
  // ---------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      highWater <= '0;
      freeTop   <= '0;
    end else if (cmdError == errNone) begin
      case (action)
        actClearHeap: begin
          allocated <= '0;
          highWater <= '0;
          freeTop   <= '0;
        end
        actAlloc: begin
          allocated[allocResult] <= 1'b1;
          if (reuse)
            freeTop <= freeTop - 1'b1;            // Pop newest freed array
          else
            highWater <= highWater + 1'b1;
        end
        actFree: begin
          allocated[array] <= 1'b0;
          freeTop          <= freeTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (action == actFree && cmdError == errNone)
      freeStack[freeTop[`HEAP_ADDRESS_BITS-1:0]] <= array;
  end

endmodule

`default_nettype wire

/* heapPkg.sv */
//----------------------------------------------------------
// Action codes, error codes and payload types of the heap.
// Action codes are sparse and fixed by the command set.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

package heapPkg;

  typedef enum logic [4:0] {
    actIdle      = 5'd0,                          // Nothing this cycle
    actClearHeap = 5'd1,                          // Unallocate every array
    actWrite     = 5'd2,                          // Store, grow size
    actRead      = 5'd3,
    actSize      = 5'd4,
    actIndex     = 5'd7,                          // Last match plus one
    actLess      = 5'd8,                          // Count below dataIn
    actGreater   = 5'd9,                          // Count above dataIn
    actPush      = 5'd14,
    actPop       = 5'd15,
    actAlloc     = 5'd18,
    actFree      = 5'd19,
    actAdd       = 5'd20,                         // Returns new value
    actAddAfter  = 5'd21,                         // Returns old value
    actSubtract  = 5'd22,
    actSubAfter  = 5'd23,
    actOr        = 5'd28,
    actXor       = 5'd29,
    actAnd       = 5'd30
  } actionT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                              // At or above high-water mark
    errFreed,                                     // Includes double free
    errOutOfBounds,                               // Index not below size
    errFull,                                      // Push on full array
    errEmpty,                                     // Pop on empty array
    errOutOfMemory                                // Alloc with nothing left
  } errorT;

  typedef logic [`HEAP_DATA_BITS-1:0]    elementT;
  typedef logic [`HEAP_INDEX_BITS:0]     sizeT;   // Reaches full length
  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayNumT;
  typedef logic [`HEAP_INDEX_BITS-1:0]   indexT;

endpackage

`default_nettype wire

/* heapTb.sv */
//----------------------------------------------------------
// Directed then random test of the heap against a reference
// model. All storage is filled once, so stale elements above
// a size are known to the model.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

module heapTb;
  import heapPkg::*;

  localparam int period        = 20;
  localparam int randomActions = 400;
  localparam int directedMax   = 120;             // Bound on directed actions
  localparam int timeoutTime   = (5 + directedMax + randomActions + 10) * period;

  typedef struct packed {
    longint unsigned at;                          // Issue time
    logic            valid;                       // Pulse expected
    errorT           err;
    elementT         data;                        // Expected dataOut
  } expectT;

  logic     clock;
  logic     resetN;
  actionT   action;
  arrayNumT array;
  indexT    index;
  elementT  dataIn;
  elementT  dataOut;
  errorT    error;
  logic     resultValid;

  int       seed;
  int       errors;
  int       checks;
  elementT  expData;                              // Held value of dataOut
  expectT   expQ [$];
  expectT   head;

  // Reference model state
  elementT  modelMem   [`HEAP_ARRAYS][`HEAP_LENGTH];
  int       modelSize  [`HEAP_ARRAYS];
  bit       modelAlloc [`HEAP_ARRAYS];
  int       modelHigh;                            // High-water mark
  int       modelFree  [$];                       // Freed arrays, newest last

  heapTop UUT (
    .clock       (clock),
    .resetN      (resetN),
    .action      (action),
    .array       (array),
    .index       (index),
    .dataIn      (dataIn),
    .dataOut     (dataOut),
    .error       (error),
    .resultValid (resultValid)
  );

  always #(period / 2) clock = ~clock;

  // ---------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------
  function automatic void predictHeap(input actionT act, input int a, input int i,
                                      input elementT din, output elementT value,
                                      output errorT err, output bit produces);
    elementT old;
    value    = '0;
    err      = errNone;
    produces = 1'b0;
    case (act)
      actIdle, actClearHeap: ;
      actAlloc:
        if (modelFree.size() == 0 && modelHigh == `HEAP_ARRAYS)
          err = errOutOfMemory;
      default:
        if (a >= modelHigh)
          err = errNotAllocated;
        else if (!modelAlloc[a])
          err = errFreed;
        else if (act inside {actRead, actAdd, actAddAfter, actSubtract, actSubAfter,
                             actOr, actXor, actAnd} && i >= modelSize[a])
          err = errOutOfBounds;
        else if (act == actPush && modelSize[a] == `HEAP_LENGTH)
          err = errFull;
        else if (act == actPop && modelSize[a] == 0)
          err = errEmpty;
    endcase
    if (err != errNone)
      return;                                     // No effect, dataOut held
    old = modelMem[a][i];
    case (act)
      actClearHeap: begin
        for (int n = 0; n < `HEAP_ARRAYS; n++) begin
          modelAlloc[n] = 1'b0;
          modelSize[n]  = 0;
        end
        modelHigh = 0;
        modelFree.delete();
      end
      actAlloc: begin
        if (modelFree.size() != 0)
          a = modelFree.pop_back();               // Newest freed first
        else begin
          a = modelHigh;
          modelHigh++;
        end
        modelAlloc[a] = 1'b1;
        modelSize[a]  = 0;
        value = elementT'(a);
      end
      actFree: begin
        modelAlloc[a] = 1'b0;
        modelFree.push_back(a);
      end
      actWrite: begin
        modelMem[a][i] = din;
        if (i >= modelSize[a])
          modelSize[a] = i + 1;
      end
      actRead: value = old;
      actSize: value = elementT'(modelSize[a]);
      actPush: begin
        modelMem[a][modelSize[a]] = din;
        modelSize[a]++;
      end
      actPop: begin
        modelSize[a]--;
        value = modelMem[a][modelSize[a]];        // Removed top
      end
      actIndex:
        for (int n = 0; n < modelSize[a]; n++)
          if (modelMem[a][n] == din)
            value = elementT'(n + 1);
      actLess:
        for (int n = 0; n < modelSize[a]; n++)
          if (modelMem[a][n] < din)
            value++;
      actGreater:
        for (int n = 0; n < modelSize[a]; n++)
          if (modelMem[a][n] > din)
            value++;
      actAdd, actAddAfter: modelMem[a][i] = old + din;
      actSubtract, actSubAfter: modelMem[a][i] = old - din;
      actOr:  modelMem[a][i] = old | din;
      actXor: modelMem[a][i] = old ^ din;
      actAnd: modelMem[a][i] = old & din;
      default: ;
    endcase
    if (act inside {actAdd, actSubtract, actOr, actXor, actAnd})
      value = modelMem[a][i];                     // New value
    else if (act inside {actAddAfter, actSubAfter})
      value = old;
    produces = !(act inside {actIdle, actClearHeap, actWrite, actPush, actFree});
  endfunction

  // ---------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------
  function automatic elementT fillValue(input int a, input int i);
    return elementT'((a << 12) | (i << 8) | ((a * 8 + i) * 3));
  endfunction

  function automatic elementT randomData();
    int r;
    r = $random(seed);
    if (r[0])
      return elementT'(r[7:4]);                   // Small, so searches match
    return elementT'(r >> 8);
  endfunction

  function automatic actionT pickAction(input int step);
    int r;
    r = $unsigned($random(seed)) % 100;
    if (step < 60 && r < 70) begin                // Build up contents early
      if (r < 15)
        return actAlloc;
      if (r < 45)
        return actWrite;
      return actPush;
    end
    if (r == 99)
      return actClearHeap;                        // Rare full reset
    case (r % 18)
      0:  return actIdle;
      1:  return actWrite;
      2:  return actRead;
      3:  return actSize;
      4:  return actPush;
      5:  return actPop;
      6:  return actAlloc;
      7:  return actFree;
      8:  return actIndex;
      9:  return actLess;
      10: return actGreater;
      11: return actAdd;
      12: return actAddAfter;
      13: return actSubtract;
      14: return actSubAfter;
      15: return actOr;
      16: return actXor;
      default: return actAnd;
    endcase
  endfunction

  // Drive one action on the falling edge and queue its expectation
  task automatic applyAction(input actionT act, input int arr, input int idx,
                             input elementT din);
    elementT value;
    errorT   err;
    bit      produces;
    expectT  e;
    @(negedge clock);
    action = act;
    array  = arrayNumT'(arr);
    index  = indexT'(idx);
    dataIn = din;
    predictHeap(act, arr, idx, din, value, err, produces);
    if (produces)
      expData = value;
    e.at    = $time;
    e.valid = (act != actIdle);
    e.err   = err;
    e.data  = expData;
    expQ.push_back(e);
  endtask

  // ---------------------------------------------------------
  // Comparison, one cycle after each action
  // ---------------------------------------------------------
  always @(negedge clock) begin
    if (expQ.size() != 0 && expQ[0].at < $time) begin
      head = expQ.pop_front();
      checks++;
      assert (resultValid == head.valid) else begin
        errors++;
        if (head.valid)
          $display("No resultValid pulse one cycle after an action, at time %0t", $time);
        else
          $display("resultValid pulsed after an idle cycle, at time %0t", $time);
      end
      assert (error == head.err) else begin
        errors++;
        $display("** Error at %0t: error is %0d, expected %0d", $time, error, head.err);
      end
      assert (dataOut == head.data) else begin
        errors++;
        $display("** Error at %0t: dataOut is %h, expected %h", $time, dataOut, head.data);
      end
    end
  end

  initial begin
    #(timeoutTime);
    $display("Run did not finish within %0d time units, stopped by watchdog", timeoutTime);
    $display("Verification failed");
    $finish;
  end

  // ---------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------
  initial begin
    actionT act;
    int     arr;
    int     idx;
    clock   = 1'b0;
    resetN  = 1'b0;
    action  = actIdle;
    array   = '0;
    index   = '0;
    dataIn  = '0;
    seed    = 32'h72fd_c38c;
    errors  = 0;
    checks  = 0;
    expData = '0;                                 // dataOut after reset
    modelHigh = 0;
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      modelSize[a]  = 0;
      modelAlloc[a] = 1'b0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;

    repeat (5) applyAction(actAlloc, 0, 0, '0);   // 0..3, then out of memory
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      for (int i = 0; i < `HEAP_LENGTH; i++) begin
        applyAction(actWrite, a, i, fillValue(a, i));
      end
    end
    applyAction(actRead, 2, 5, '0);
    applyAction(actSize, 3, 0, '0);
    applyAction(actFree, 2, 0, '0);
    applyAction(actFree, 1, 0, '0);
    applyAction(actFree, 1, 0, '0);               // Double free
    applyAction(actRead, 2, 0, '0);               // Freed array
    repeat (3) applyAction(actAlloc, 0, 0, '0);   // 1, 2, then out of memory
    applyAction(actPush, 3, 0, 16'h00aa);         // Full
    applyAction(actPop, 1, 0, '0);                // Empty
    applyAction(actRead, 1, 0, '0);               // Out of bounds
    for (int i = 0; i < 3; i++) begin
      applyAction(actPush, 1, 0, elementT'(16'h0050 + i));
    end
    applyAction(actSize, 1, 0, '0);
    applyAction(actPop, 1, 0, '0);
    applyAction(actWrite, 0, 6, fillValue(0, 2)); // Second match for index
    applyAction(actIndex, 0, 0, fillValue(0, 2));
    applyAction(actLess, 0, 0, fillValue(0, 4));
    applyAction(actGreater, 0, 0, fillValue(0, 4));
    applyAction(actAdd, 0, 1, 16'h0003);
    applyAction(actAddAfter, 0, 1, 16'h0003);
    applyAction(actSubtract, 0, 2, 16'h0100);
    applyAction(actSubAfter, 0, 2, 16'hffff);
    applyAction(actOr, 0, 3, 16'h8001);
    applyAction(actXor, 0, 4, 16'h00ff);
    applyAction(actAnd, 0, 5, 16'h0f0f);
    applyAction(actRead, 0, 1, '0);
    applyAction(actClearHeap, 0, 0, '0);
    applyAction(actRead, 0, 0, '0);               // Not allocated
    applyAction(actIdle, 0, 0, '0);
    applyAction(actAlloc, 0, 0, '0);

    for (int step = 0; step < randomActions; step++) begin
      act = pickAction(step);
      arr = $random(seed) & 3;                    // May hit free or unused arrays
      idx = $random(seed) & 7;                    // May exceed the size
      applyAction(act, arr, idx, randomData());
    end

    applyAction(actIdle, 0, 0, '0);
    @(negedge clock);
    @(posedge clock);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* heapTop.sv */
//----------------------------------------------------------
// Heap of fixed-size arrays. One action per cycle, no
// handshake; results appear one cycle later.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

module heapTop (
  input  logic               clock,
  input  logic               resetN,
  input  heapPkg::actionT    action,
  input  heapPkg::arrayNumT  array,
  input  heapPkg::indexT     index,
  input  heapPkg::elementT   dataIn,
  output heapPkg::elementT   dataOut,
  output heapPkg::errorT     error,
  output logic               resultValid
);
  import heapPkg::*;

  logic [`HEAP_ARRAYS-1:0] bankSelect;            // One hot, legal actions only
  logic [`HEAP_ARRAYS-1:0] bankClear;
  actionT                  bankAction;
  arrayNumT                allocResult;
  errorT                   cmdError;
  sizeT                    bankSizes   [`HEAP_ARRAYS];
  elementT                 bankResults [`HEAP_ARRAYS];

  commandDecoder decoder (
    .clock       (clock),
    .resetN      (resetN),
    .action      (action),
    .array       (array),
    .index       (index),
    .bankSizes   (bankSizes),
    .bankSelect  (bankSelect),
    .bankClear   (bankClear),
    .bankAction  (bankAction),
    .allocResult (allocResult),
    .cmdError    (cmdError)
  );

  // One bank per array
  for (genvar b = 0; b < `HEAP_ARRAYS; b++) begin : bankGen
    arrayBank bank (
      .clock  (clock),
      .resetN (resetN),
      .select (bankSelect[b]),
      .clear  (bankClear[b]),
      .action (bankAction),
      .index  (index),
      .dataIn (dataIn),
      .size   (bankSizes[b]),
      .result (bankResults[b])
    );
  end

  resultCollector collector (
    .clock       (clock),
    .resetN      (resetN),
    .action      (action),
    .array       (array),
    .bankResults (bankResults),
    .allocResult (allocResult),
    .cmdError    (cmdError),
    .dataOut     (dataOut),
    .error       (error),
    .resultValid (resultValid)
  );

endmodule

`default_nettype wire

/* heap_consts.svh */
//----------------------------------------------------------
// Heap geometry. The counts follow from the bit widths, so
// only the widths should be changed. Arrays and lengths are
// powers of two.
//----------------------------------------------------------
`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

`define HEAP_ADDRESS_BITS 2                       // Bits in an array number
`define HEAP_INDEX_BITS   3                       // Bits in an element index
`define HEAP_DATA_BITS    16                      // Element width

`define HEAP_ARRAYS (1 << `HEAP_ADDRESS_BITS)     // 4 arrays
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)       // 8 elements per array

`endif

/* heap_sva.sv */
//----------------------------------------------------------
// Output protocol checks for heapTop, bound to every
// instance. Outputs only, no view of the arrays.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

module heapSva (
  input logic              clock,
  input logic              resetN,
  input heapPkg::actionT   action,
  input heapPkg::elementT  dataOut,
  input heapPkg::errorT    error,
  input logic              resultValid
);
  import heapPkg::*;

  logic seenValid;                                // Any result since reset

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      seenValid <= 1'b0;
    else if (resultValid)
      seenValid <= 1'b1;
  end

  validAfterAction: assert property (@(posedge clock) disable iff (!resetN)
    action != actIdle |=> resultValid)
    else $error("resultValid missing one cycle after an action");

  quietAfterIdle: assert property (@(posedge clock) disable iff (!resetN)
    action == actIdle |=> !resultValid)
    else $error("resultValid pulsed after an idle cycle");

  errorOnlyWithValid: assert property (@(posedge clock) disable iff (!resetN)
    !resultValid |-> error == errNone)
    else $error("error set without resultValid");

  // Reset values hold until the first result
  resetOutputs: assert property (@(posedge clock) disable iff (!resetN)
    (!seenValid && !resultValid) |-> (dataOut == '0 && error == errNone))
    else $error("outputs left reset values before any result");

endmodule

bind heapTop heapSva assertions (
  .clock       (clock),
  .resetN      (resetN),
  .action      (action),
  .dataOut     (dataOut),
  .error       (error),
  .resultValid (resultValid)
);

`default_nettype wire

/* resultCollector.sv */
//----------------------------------------------------------
// Output register stage. dataOut holds its value for
// actions in error or without a result.
//----------------------------------------------------------
`default_nettype none
`include "heap_consts.svh"

module resultCollector (
  input  logic               clock,
  input  logic               resetN,
  input  heapPkg::actionT    action,
  input  heapPkg::arrayNumT  array,
  input  heapPkg::elementT   bankResults [`HEAP_ARRAYS],
  input  heapPkg::arrayNumT  allocResult,
  input  heapPkg::errorT     cmdError,
  output heapPkg::elementT   dataOut,
  output heapPkg::errorT     error,
  output logic               resultValid
);
  import heapPkg::*;

  logic    producesValue;                         // Action returns data
  elementT nextData;

  assign nextData = (action == actAlloc) ? elementT'(allocResult) : bankResults[array];

  always_comb begin
    case (action)
      actRead, actSize, actPop, actAlloc, actIndex, actLess, actGreater,
      actAdd, actAddAfter, actSubtract, actSubAfter, actOr, actXor, actAnd:
        producesValue = 1'b1;
      default:
        producesValue = 1'b0;                     // Write, push, free, clear
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut     <= '0;
      error       <= errNone;
      resultValid <= 1'b0;
    end else begin
      resultValid <= (action != actIdle);         // One pulse per action
      error       <= cmdError;
      if (producesValue && cmdError == errNone)
        dataOut <= nextData;
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
heapPkg.sv
commandDecoder.sv
arrayBank.sv
resultCollector.sv
heapTop.sv
heap_sva.sv
heapTb.sv
